// File: list.f
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_frame_ctrl.sv
hdl/spi_regfile.sv
hdl/spi_tx_shift.sv
hdl/spi_slave_top.sv
bench/spi_clkgen.sv
bench/tb_spi_slave.sv

// File: bench/tb_spi_slave.sv
/* spi slave testbench */

`timescale 1ns/1ps

`include "spi_defines.svh"

module tb_spi_slave;

   // frames in the run and their lengths in bytes, command byte included
   localparam int NUM_FRAMES  = 10;
   localparam int NUM_BYTES   = 9 + 9 + 5 + 5 + 5 + 5 + 5 + 5 + 5 + 5;
   localparam int CYCLE_LIMIT = 2 * (8 * NUM_BYTES + 4 * NUM_FRAMES);

   logic               sclk;
   logic               ss;
   logic               mosi;
   logic               spi_en;
   logic               lsbfirst;
   logic               miso;
   logic               wr_strobe;
   spi_pkg::spi_addr_t wr_addr;
   spi_pkg::spi_data_t wr_data;

   integer             seed = 32'h0591_671d;
   int                 err_count   = 0;
   int                 check_count = 0;
   int                 cycle_cnt   = 0;
   int                 test_errs;                   // errors before current test
   logic               miso_high;                   // miso seen nonzero in last frame
   spi_pkg::spi_addr_t start1;
   spi_pkg::spi_addr_t start3;
   spi_pkg::spi_data_t model  [`SPI_NREGS];         // reference register file
   spi_pkg::spi_data_t tx_buf [64];                 // data bytes sent on mosi
   spi_pkg::spi_data_t rx_buf [64];                 // bytes collected from miso
   spi_pkg::spi_addr_t exp_addr_q [$];              // pending write strobes
   spi_pkg::spi_data_t exp_data_q [$];

   spi_clkgen u_clkgen (.sclk(sclk));

   spi_slave_top u_dut (
      .sclk      (sclk),
      .ss        (ss),
      .mosi      (mosi),
      .spi_en    (spi_en),
      .lsbfirst  (lsbfirst),
      .miso      (miso),
      .wr_strobe (wr_strobe),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data)
   );

   //####################################################################
   // reference model and compare tasks
   //####################################################################

   // byte number count of a read burst, address wraps at 64
   function automatic spi_pkg::spi_data_t expected_read(input spi_pkg::spi_addr_t start,
                                                        input int count);
      return model[(int'(start) + count) % `SPI_NREGS];
   endfunction

   function automatic spi_pkg::spi_byte_u make_cmd(input logic [1:0] op,
                                                   input spi_pkg::spi_addr_t addr);
      spi_pkg::spi_byte_u b;
      b.cmd.op   = spi_pkg::spi_op_e'(op);
      b.cmd.addr = addr;
      return b;
   endfunction

   function automatic spi_pkg::spi_data_t rand_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic spi_pkg::spi_addr_t rand_addr();
      logic [31:0] r;
      r = $random(seed);
      return r[5:0];
   endfunction

   task automatic check_data(input string name, input spi_pkg::spi_data_t got,
                             input spi_pkg::spi_data_t exp);
      check_count++;
      if (got !== exp) begin
         $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_addr(input string name, input spi_pkg::spi_addr_t got,
                             input spi_pkg::spi_addr_t exp);
      check_count++;
      if (got !== exp) begin
         $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   // every queued write must have shown up by now
   task automatic check_writes_done();
      check_count++;
      if (exp_addr_q.size() != 0) begin
         $display("%0d expected write strobes never arrived", exp_addr_q.size());
         err_count++;
         exp_addr_q.delete();
         exp_data_q.delete();
      end
   endtask

   task automatic check_miso_quiet();
      check_count++;
      if (miso_high) begin
         $display("miso went high during a frame the slave should ignore");
         err_count++;
      end
   endtask

   // expected strobes and model update for a write burst
   task automatic queue_writes(input spi_pkg::spi_addr_t start, input int n);
      spi_pkg::spi_addr_t a;
      for (int i = 0; i < n; i++) begin
         a = spi_pkg::spi_addr_t'((int'(start) + i) % `SPI_NREGS);
         exp_addr_q.push_back(a);
         exp_data_q.push_back(tx_buf[i]);
         model[a] = tx_buf[i];
      end
   endtask

   task automatic check_reads(input spi_pkg::spi_addr_t start, input int n);
      for (int i = 0; i < n; i++) begin
         check_data("miso byte", rx_buf[i], expected_read(start, i));
      end
   endtask

   task automatic fill_data(input int n);
      for (int i = 0; i < n; i++) begin
         tx_buf[i] = rand_byte();
      end
   endtask

   task automatic report_test(input string name);
      if (err_count == test_errs) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, err_count - test_errs);
      test_errs = err_count;
   endtask

   //####################################################################
   // master model
   //####################################################################

   // mode change only while ss is high
   task automatic set_mode(input logic en, input logic lsb);
      @(posedge sclk);
      spi_en   <= en;
      lsbfirst <= lsb;
   endtask

   // command plus nbytes data periods, miso collected per period
   task automatic run_frame(input spi_pkg::spi_byte_u cmd, input int nbytes);
      int                 nbits;
      int                 pos;
      int                 idx;
      spi_pkg::spi_data_t cur;
      spi_pkg::spi_data_t rx_byte;
      nbits     = 8 * (nbytes + 1);
      miso_high = 1'b0;
      rx_byte   = '0;
      for (int k = 0; k <= nbits; k++) begin
         @(posedge sclk);
         if (k > 0) begin                              // bit sampled by slave now
            pos = (k - 1) % 8;
            idx = lsbfirst ? pos : 7 - pos;
            rx_byte[idx] = miso;
            if (miso !== 1'b0) miso_high = 1'b1;
            if (pos == 7 && k > 8) rx_buf[(k - 1) / 8 - 1] = rx_byte;
         end
         if (k < nbits) begin
            pos = k % 8;
            idx = lsbfirst ? pos : 7 - pos;            // wire order
            cur = (k < 8) ? cmd.raw : tx_buf[k / 8 - 1];
            mosi <= cur[idx];
            if (k == 0) ss <= 1'b0;                    // frame start
         end else begin
            mosi <= 1'b0;                              // idle cycle, last write lands
         end
      end
      @(posedge sclk);
      ss <= 1'b1;
      @(posedge sclk);
   endtask

   //####################################################################
   // write port monitor and timeout
   //####################################################################

   // strobe is registered on the rising edge, stable at the falling one
   always @(negedge sclk) begin
      if (wr_strobe === 1'b1) begin
         if (exp_addr_q.size() == 0) begin
            $display("unexpected write strobe, address 0x%h data 0x%h", wr_addr, wr_data);
            err_count++;
         end else begin
            check_addr("wr_addr", wr_addr, exp_addr_q.pop_front());
            check_data("wr_data", wr_data, exp_data_q.pop_front());
         end
      end
   end

   always @(posedge sclk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, tests did not finish", cycle_cnt);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   //####################################################################
   // tests
   //####################################################################

   initial begin
      ss        = 1'b1;   // slave idle
      mosi      = 1'b0;
      spi_en    = 1'b1;
      lsbfirst  = 1'b0;
      test_errs = 0;
      for (int i = 0; i < `SPI_NREGS; i++) model[i] = '0;
      repeat (5) @(posedge sclk);

      // 1, msb first write burst
      start1 = rand_addr();
      fill_data(8);
      queue_writes(start1, 8);
      run_frame(make_cmd(`SPI_OP_WRITE, start1), 8);
      check_writes_done();
      report_test("1 write burst");

      // 2, read the same region back
      run_frame(make_cmd(`SPI_OP_READ, start1), 8);
      check_reads(start1, 8);
      report_test("2 read burst");

      // 3, lsb first on the wire
      set_mode(1'b1, 1'b1);
      start3 = rand_addr();
      fill_data(4);
      queue_writes(start3, 4);
      run_frame(make_cmd(`SPI_OP_WRITE, start3), 4);
      check_writes_done();
      run_frame(make_cmd(`SPI_OP_READ, start3), 4);
      check_reads(start3, 4);
      set_mode(1'b1, 1'b0);
      report_test("3 lsb first");

      // 4, 62 63 0 1
      fill_data(4);
      queue_writes(6'd62, 4);
      run_frame(make_cmd(`SPI_OP_WRITE, 6'd62), 4);
      check_writes_done();
      run_frame(make_cmd(`SPI_OP_READ, 6'd62), 4);
      check_reads(6'd62, 4);
      report_test("4 address wrap");

      // 5, disabled slave drops the write
      set_mode(1'b0, 1'b0);
      fill_data(4);                                     // not queued, model unchanged
      run_frame(make_cmd(`SPI_OP_WRITE, start1), 4);
      check_miso_quiet();
      set_mode(1'b1, 1'b0);
      run_frame(make_cmd(`SPI_OP_READ, start1), 4);
      check_reads(start1, 4);
      report_test("5 spi_en low");

      // 6, reserved opcodes
      fill_data(4);
      run_frame(make_cmd(2'b01, rand_addr()), 4);
      check_miso_quiet();
      fill_data(4);
      run_frame(make_cmd(2'b10, rand_addr()), 4);
      check_miso_quiet();
      report_test("6 reserved opcodes");

      $display("done, %0d checks, %0d errors", check_count, err_count);
      if (err_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: bench/spi_clkgen.sv
/* testbench clock */

`timescale 1ns/1ps

module spi_clkgen (
   output logic sclk
);

   localparam real HALF_PERIOD = 50.0;   // 100 ns period

   // free running from time zero, first rising edge at 50 ns
   initial begin
      sclk = 1'b0;
      forever #(HALF_PERIOD) sclk = ~sclk;
   end

endmodule

// File: hdl/spi_slave_top.sv
/* spi slave top */

`timescale 1ns/1ps

module spi_slave_top (
   input  logic               sclk,
   input  logic               ss,
   input  logic               mosi,
   input  logic               spi_en,
   input  logic               lsbfirst,
   output logic               miso,
   output logic               wr_strobe,   // register update, for the chip
   output spi_pkg::spi_addr_t wr_addr,
   output spi_pkg::spi_data_t wr_data
);

   spi_pkg::spi_addr_t rd_addr;
   spi_pkg::spi_data_t rd_data;
   logic               tx_load;

   //####################################################################
   // stage 1, frame control and receive
   //####################################################################

   spi_frame_ctrl u_frame_ctrl (
      .sclk      (sclk),
      .ss        (ss),
      .mosi      (mosi),
      .spi_en    (spi_en),
      .lsbfirst  (lsbfirst),
      .wr_strobe (wr_strobe),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rd_addr   (rd_addr),
      .tx_load   (tx_load)
   );

   //####################################################################
   // stage 2, register storage
   //####################################################################

   spi_regfile u_regfile (
      .sclk      (sclk),
      .wr_strobe (wr_strobe),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   //####################################################################
   // stage 3, transmit shift
   //####################################################################

   spi_tx_shift u_tx_shift (
      .sclk      (sclk),
      .ss        (ss),
      .lsbfirst  (lsbfirst),
      .tx_load   (tx_load),
      .rd_data   (rd_data),
      .miso      (miso)
   );

endmodule

// File: hdl/spi_tx_shift.sv
/* spi transmit shifter */

`timescale 1ns/1ps

module spi_tx_shift (
   input  logic               sclk,
   input  logic               ss,        // clears tx register
   input  logic               lsbfirst,
   input  logic               tx_load,   // one cycle pulse from frame ctrl
   input  spi_pkg::spi_data_t rd_data,
   output logic               miso
);

   spi_pkg::spi_data_t tx_reg;   // outgoing byte

   //####################################################################
   // falling edge shifter
   //####################################################################

   // mode 0, miso changes on the falling edge
   always_ff @(negedge sclk or posedge ss) begin
      if (ss) begin
         tx_reg <= '0;
      end else if (tx_load) begin
         tx_reg <= rd_data;               // new byte, leading bit out now
      end else if (lsbfirst) begin
         tx_reg <= {1'b0, tx_reg[7:1]};   // toward lsb, zero fill
      end else begin
         tx_reg <= {tx_reg[6:0], 1'b0};   // toward msb, zero fill
      end
   end

   // leading end of the register
   // empty register keeps miso low outside read frames
   assign miso = lsbfirst ? tx_reg[0] : tx_reg[7];

endmodule

// File: hdl/spi_regfile.sv
/* spi register storage */

`timescale 1ns/1ps

`include "spi_defines.svh"

module spi_regfile (
   input  logic               sclk,
   input  logic               wr_strobe,
   input  spi_pkg::spi_addr_t wr_addr,
   input  spi_pkg::spi_data_t wr_data,
   input  spi_pkg::spi_addr_t rd_addr,
   output spi_pkg::spi_data_t rd_data
);

   // contents kept across frames
   spi_pkg::spi_data_t mem [`SPI_NREGS];

   //####################################################################
   // write port
   //####################################################################

   // one cycle after the strobe is raised
   always_ff @(posedge sclk) begin
      if (wr_strobe) begin
         mem[wr_addr] <= wr_data;
      end
   end

   //####################################################################
   // read port
   //####################################################################

   // combinational, sampled by tx shifter on falling edge
   assign rd_data = mem[rd_addr];

endmodule

// File: hdl/spi_frame_ctrl.sv
/* spi frame control and receive */

`timescale 1ns/1ps

module spi_frame_ctrl (
   input  logic              sclk,
   input  logic              ss,        // async clear, frame idle
   input  logic              mosi,
   input  logic              spi_en,
   input  logic              lsbfirst,
   output logic              wr_strobe,
   output spi_pkg::spi_addr_t wr_addr,
   output spi_pkg::spi_data_t wr_data,
   output spi_pkg::spi_addr_t rd_addr,
   output logic              tx_load
);

   typedef enum logic [1:0] {
      ST_IDLE,   // ss high, or first edge of a frame
      ST_CMD,    // collecting command byte
      ST_DATA,   // data bytes, read or write
      ST_SKIP    // frame ignored until ss rises
   } state_e;

   state_e             state;
   logic [2:0]         bit_cnt;    // bits of current byte
   logic [7:0]         rx_shift;   // partial byte
   spi_pkg::spi_byte_u rx_next;    // byte incl. bit on this edge
   spi_pkg::spi_op_e   op;         // latched opcode
   spi_pkg::spi_addr_t cur_addr;   // auto incrementing address
   logic               byte_done;
   logic               cmd_done;
   logic               data_done;
   logic               cmd_ok;

   //####################################################################
   // receive shifter
   //####################################################################

   // next byte value with mosi merged in
   always_comb begin
      if (lsbfirst) begin
         rx_next.raw = {mosi, rx_shift[7:1]};  // fill from the top
      end else begin
         rx_next.raw = {rx_shift[6:0], mosi};  // fill from the bottom
      end
   end

   always_ff @(posedge sclk) begin
      rx_shift <= rx_next.raw;
   end

   // bit counter, wraps every byte
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         bit_cnt <= 3'd0;   // drops any partial byte
      end else begin
         bit_cnt <= bit_cnt + 3'd1;
      end
   end

   assign byte_done = (bit_cnt == 3'd7);   // 8th bit sampled now
   assign cmd_done  = byte_done && (state == ST_CMD);
   assign data_done = byte_done && (state == ST_DATA);

   // only write and read commands open a data phase
   assign cmd_ok = spi_en &&
                   ((rx_next.cmd.op == spi_pkg::SPI_OP_WRITE) ||
                    (rx_next.cmd.op == spi_pkg::SPI_OP_READ));

   //####################################################################
   // frame state machine
   //####################################################################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: state <= ST_CMD;
            ST_CMD: begin
               if (byte_done) begin
                  state <= cmd_ok ? ST_DATA : ST_SKIP;
               end
            end
            ST_DATA: state <= ST_DATA;   // until ss
            default: state <= ST_SKIP;
         endcase
      end
   end

   // command latch and address counter
   always_ff @(posedge sclk) begin
      if (cmd_done) begin
         op       <= rx_next.cmd.op;
         cur_addr <= rx_next.cmd.addr;
      end else if (data_done) begin
         cur_addr <= cur_addr + 1'b1;   // wraps at 64
      end
   end

   assign rd_addr = cur_addr;   // registered address to regfile

   //####################################################################
   // strobes
   //####################################################################

   // write strobe one cycle after the last bit of a data byte
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         wr_strobe <= 1'b0;
      end else begin
         wr_strobe <= data_done && (op == spi_pkg::SPI_OP_WRITE);
      end
   end

   // write payload, no reset
   always_ff @(posedge sclk) begin
      if (data_done) begin
         wr_addr <= cur_addr;
         wr_data <= rx_next.raw;   // data view of the same byte
      end
   end

   // load pulse for the tx shifter, after command and each read byte
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         tx_load <= 1'b0;
      end else if (cmd_done) begin
         tx_load <= cmd_ok && (rx_next.cmd.op == spi_pkg::SPI_OP_READ);
      end else begin
         tx_load <= data_done && (op == spi_pkg::SPI_OP_READ);
      end
   end

endmodule

// File: hdl/spi_pkg.sv
/* spi slave types */

`include "spi_defines.svh"

package spi_pkg;

   // opcode field of the command byte
   typedef enum logic [1:0] {
      SPI_OP_WRITE = `SPI_OP_WRITE,
      SPI_OP_RSVD1 = 2'b01,          // ignored
      SPI_OP_RSVD2 = 2'b10,          // ignored
      SPI_OP_READ  = `SPI_OP_READ
   } spi_op_e;

   typedef logic [`SPI_AW-1:0] spi_addr_t;  // register address
   typedef logic [`SPI_DW-1:0] spi_data_t;  // register data

   // command view, op in the top bits
   typedef struct packed {
      spi_op_e   op;
      spi_addr_t addr;
   } spi_cmd_t;

   // one received byte, command or data depending on frame state
   typedef union packed {
      spi_cmd_t  cmd;
      spi_data_t raw;
   } spi_byte_u;

endpackage

// File: hdl/spi_defines.svh
/* spi slave constants */

`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// register file depth
`define SPI_NREGS 64

// field widths
`define SPI_AW 6
`define SPI_DW 8

// command opcodes, upper two bits of the command byte
`define SPI_OP_WRITE 2'b00
`define SPI_OP_READ  2'b11

`endif
